// File: src/spi_pkg.sv
package spi_pkg;

  // One byte on the wire, sent MSB first
  typedef logic [7:0] spi_byte_t;

  // Command or reply word, eight bytes sent LSB byte first
  // [63:56] opcode, [55:48] address, [47:32] frame count, [31:0] data
  typedef logic [63:0] spi_word_t;

  // Register contents
  typedef logic [31:0] spi_data_t;

  // Register address field
  typedef logic [7:0] spi_addr_t;

  // Opcode field
  typedef logic [7:0] spi_opcode_t;

  // Number of command words seen, wraps
  typedef logic [15:0] spi_frame_cnt_t;

  localparam spi_opcode_t OP_WRITE = 8'h01;
  localparam spi_opcode_t OP_READ  = 8'h02;
  // Returned for bad opcodes and out of range addresses
  localparam spi_opcode_t OP_ERROR = 8'hEE;

endpackage

// File: src/spi_input_sync.sv
`timescale 1ns/1ps

module spi_input_sync (
  input  logic clk,
  input  logic arst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  output logic sck_rise,
  output logic sck_fall,
  output logic sel,
  output logic copi_bit
);

  // Three flops per pin, bit 0 takes the raw pin, bit 2 is the oldest
  logic [2:0] sck_q;
  logic [2:0] cs_n_q;
  logic [2:0] copi_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_q  <= '0;
      // Chip select idles deasserted
      cs_n_q <= '1;
      copi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_n_q <= {cs_n_q[1:0], cs_n};
      copi_q <= {copi_q[1:0], copi};
    end
  end

  // Edges from the two oldest SCK samples
  assign sck_rise = (sck_q[2:1] == 2'b01);
  assign sck_fall = (sck_q[2:1] == 2'b10);

  // Active low select turned into a level
  assign sel      = ~cs_n_q[2];
  assign copi_bit = copi_q[2];

endmodule

// File: src/spi_byte_engine.sv
`timescale 1ns/1ps

module spi_byte_engine (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               sck_rise,
  input  logic               sck_fall,
  input  logic               sel,
  input  logic               copi_bit,
  input  spi_pkg::spi_byte_t tx_byte,
  output spi_pkg::spi_byte_t rx_byte,
  output logic               rx_strobe,
  output logic               cipo,
  output logic               cipo_oe
);

  // Receive bit count, steps up on rising SCK
  logic [2:0] rx_cnt;
  // Transmit bit index, steps down on falling SCK, MSB first
  logic [2:0] tx_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_cnt    <= 3'd0;
      tx_cnt    <= 3'd7;
      rx_strobe <= 1'b0;
    end else begin
      // Strobe is a single cycle pulse
      rx_strobe <= 1'b0;
      if (!sel) begin
        // Deselect restarts both counters so a broken frame starts clean
        rx_cnt <= 3'd0;
        tx_cnt <= 3'd7;
      end else begin
        if (sck_rise) begin
          rx_cnt    <= rx_cnt + 3'd1;
          // Eighth bit completes the byte
          rx_strobe <= (rx_cnt == 3'd7);
        end
        if (sck_fall) begin
          // Wraps from 0 back to 7 for the next byte
          tx_cnt <= tx_cnt - 3'd1;
        end
      end
    end
  end

  // Shift register for incoming COPI bits, MSB arrives first
  always_ff @(posedge clk) begin
    if (sel && sck_rise) begin
      rx_byte <= {rx_byte[6:0], copi_bit};
    end
  end

  // Mode 0, bit 7 is on the line as soon as select is seen
  assign cipo    = tx_byte[tx_cnt];
  // Pad driver enable, the chip level builds the tristate
  assign cipo_oe = sel;

endmodule

// File: src/spi_word_framer.sv
`timescale 1ns/1ps

module spi_word_framer (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               sel,
  input  logic               rx_strobe,
  input  spi_pkg::spi_byte_t rx_byte,
  input  spi_pkg::spi_word_t reply_word,
  output spi_pkg::spi_byte_t tx_byte,
  output spi_pkg::spi_word_t cmd_word,
  output logic               cmd_valid
);

  // Position of the current byte inside the 64-bit word
  logic [2:0] byte_idx;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_idx  <= 3'd0;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (!sel) begin
        // Aborted or finished frame, next one starts at byte 0
        byte_idx <= 3'd0;
      end else if (rx_strobe) begin
        // Wraps after byte 7 so back to back words share one frame
        byte_idx  <= byte_idx + 3'd1;
        cmd_valid <= (byte_idx == 3'd7);
      end
    end
  end

  // New byte enters at the top
  // After eight bytes the first one sits in bits 7..0
  always_ff @(posedge clk) begin
    if (rx_strobe) begin
      cmd_word <= {rx_byte, cmd_word[63:8]};
    end
  end

  // Reply goes out little endian, byte n while receiving byte n
  assign tx_byte = reply_word[{byte_idx, 3'b000} +: 8];

endmodule

// File: src/spi_command_regs.sv
`timescale 1ns/1ps

module spi_command_regs #(
  parameter int NUM_REGS = 4
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               cmd_valid,
  input  spi_pkg::spi_word_t cmd_word,
  output spi_pkg::spi_word_t reply_word,
  output spi_pkg::spi_data_t ctrl
);

  import spi_pkg::*;

  // Register bank, entry 0 doubles as the control output
  spi_data_t      regs [NUM_REGS];
  spi_frame_cnt_t frame_cnt;
  spi_frame_cnt_t frame_cnt_next;

  // Command fields
  spi_opcode_t    cmd_op;
  spi_addr_t      cmd_addr;
  spi_data_t      cmd_data;

  logic           addr_ok;
  logic           is_write;
  logic           is_read;
  logic           cmd_ok;
  spi_data_t      cur_val;
  spi_data_t      new_val;
  spi_opcode_t    reply_op;
  spi_data_t      reply_data;

  // Bits 47..32 of a command carry nothing
  assign cmd_op   = cmd_word[63:56];
  assign cmd_addr = cmd_word[55:48];
  assign cmd_data = cmd_word[31:0];

  assign addr_ok  = (int'(cmd_addr) < NUM_REGS);
  assign is_write = (cmd_op == OP_WRITE);
  assign is_read  = (cmd_op == OP_READ);
  assign cmd_ok   = addr_ok && (is_write || is_read);

  // Counter steps before the reply is built
  assign frame_cnt_next = frame_cnt + 16'd1;

  // Addressed register, compare based so any bank size is safe
  always_comb begin
    cur_val = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      if (int'(cmd_addr) == i) begin
        cur_val = regs[i];
      end
    end
  end

  // Value after the command, reads leave it as is
  assign new_val    = is_write ? cmd_data : cur_val;
  assign reply_op   = cmd_ok ? cmd_op : OP_ERROR;
  // Error replies carry zero data
  assign reply_data = cmd_ok ? new_val : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      frame_cnt  <= '0;
      reply_word <= '0;
    end else if (cmd_valid) begin
      frame_cnt <= frame_cnt_next;
      // Only a good write touches the bank
      if (cmd_ok && is_write) begin
        for (int i = 0; i < NUM_REGS; i++) begin
          if (int'(cmd_addr) == i) begin
            regs[i] <= cmd_data;
          end
        end
      end
      // Held until the next command, shifted out in the next frame
      reply_word <= {reply_op, cmd_addr, frame_cnt_next, reply_data};
    end
  end

  assign ctrl = regs[0];

endmodule

// File: src/spi_word_target.sv
`timescale 1ns/1ps

module spi_word_target #(
  parameter int NUM_REGS = 4
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               copi,
  output logic               cipo,
  output logic               cipo_oe,
  output spi_pkg::spi_data_t ctrl
);

  import spi_pkg::*;

  // Synchronized pin events
  logic      sck_rise;
  logic      sck_fall;
  logic      sel;
  logic      copi_bit;

  // Byte level traffic
  spi_byte_t rx_byte;
  logic      rx_strobe;
  spi_byte_t tx_byte;

  // Word level traffic
  spi_word_t cmd_word;
  logic      cmd_valid;
  spi_word_t reply_word;

  spi_input_sync u_sync (
    .clk      (clk),
    .arst_n   (arst_n),
    .sck      (sck),
    .cs_n     (cs_n),
    .copi     (copi),
    .sck_rise (sck_rise),
    .sck_fall (sck_fall),
    .sel      (sel),
    .copi_bit (copi_bit)
  );

  spi_byte_engine u_byte (
    .clk       (clk),
    .arst_n    (arst_n),
    .sck_rise  (sck_rise),
    .sck_fall  (sck_fall),
    .sel       (sel),
    .copi_bit  (copi_bit),
    .tx_byte   (tx_byte),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe),
    .cipo      (cipo),
    .cipo_oe   (cipo_oe)
  );

  spi_word_framer u_framer (
    .clk        (clk),
    .arst_n     (arst_n),
    .sel        (sel),
    .rx_strobe  (rx_strobe),
    .rx_byte    (rx_byte),
    .reply_word (reply_word),
    .tx_byte    (tx_byte),
    .cmd_word   (cmd_word),
    .cmd_valid  (cmd_valid)
  );

  // Reply to command k leaves during frame k+1
  spi_command_regs #(
    .NUM_REGS (NUM_REGS)
  ) u_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .reply_word (reply_word),
    .ctrl       (ctrl)
  );

endmodule

// File: tests/tb_spi_word_target.sv
`timescale 1ns/1ps

module tb_spi_word_target;

  import spi_pkg::*;

  localparam int NUM_REGS    = 4;
  // SCK half period in clk cycles
  localparam int HALF        = 6;
  localparam int HALF_NS     = HALF * 8;
  localparam int MAX_FRAMES  = 48;
  // 64 bits take 128 half periods and the rest covers select setup and gaps
  localparam int WATCHDOG_NS = MAX_FRAMES * 144 * HALF_NS + 20000;

  logic      clk;
  logic      arst_n;
  logic      sck;
  logic      cs_n;
  logic      copi;
  logic      cipo;
  logic      cipo_oe;
  spi_data_t ctrl;

  // Reference model state
  spi_data_t      ref_regs [256];
  spi_frame_cnt_t ref_cnt;
  spi_word_t      exp_reply;
  logic [31:0]    rng_state;

  spi_word_target #(
    .NUM_REGS (NUM_REGS)
  ) u_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .sck     (sck),
    .cs_n    (cs_n),
    .copi    (copi),
    .cipo    (cipo),
    .cipo_oe (cipo_oe),
    .ctrl    (ctrl)
  );

  always #4 clk = ~clk;

  task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
    assert (got === exp) else begin
      $display("FAILED at %0d ns: %s, got 0x%h, expected 0x%h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // xorshift32 step
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // SPI mode 0 host sending the LSB byte first and each byte MSB first
  // Stopping after nbits lets a short count model an aborted frame
  task automatic spi_xfer_word(input spi_word_t tx, input int nbits, output spi_word_t rx);
    int b;
    rx = '0;
    @(negedge clk);
    cs_n = 1'b0;
    wait_cycles(HALF);
    for (int i = 0; i < nbits; i++) begin
      b = (i / 8) * 8 + 7 - (i % 8);
      // Data changes with the falling SCK
      copi = tx[b];
      wait_cycles(HALF);
      sck = 1'b1;
      rx[b] = cipo;
      compare_value(64'(cipo_oe), 64'd1, "cipo_oe during frame");
      wait_cycles(HALF);
      sck = 1'b0;
    end
    // Target needs time after the last edge before deselect
    wait_cycles(HALF + 2);
    cs_n = 1'b1;
    copi = 1'b0;
    wait_cycles(HALF + 2);
  endtask

  // Reply rule applied to one command word
  task automatic model_command(input spi_word_t cmd);
    spi_opcode_t op;
    spi_addr_t   addr;
    logic        ok;
    op   = cmd[63:56];
    addr = cmd[55:48];
    ref_cnt = ref_cnt + 16'd1;
    ok = (int'(addr) < NUM_REGS) && (op == OP_WRITE || op == OP_READ);
    if (ok && op == OP_WRITE) begin
      ref_regs[addr] = cmd[31:0];
    end
    if (ok) begin
      exp_reply = {op, addr, ref_cnt, ref_regs[addr]};
    end else begin
      exp_reply = {OP_ERROR, addr, ref_cnt, 32'h0};
    end
  endtask

  // Full frame whose reply belongs to the previous command
  task automatic run_command(input spi_word_t cmd, output spi_word_t got);
    spi_xfer_word(cmd, 64, got);
    compare_value(got, exp_reply, "reply word");
    model_command(cmd);
    compare_value(64'(ctrl), 64'(ref_regs[0]), "ctrl after frame");
  endtask

  task automatic idle_after_reset();
    wait_cycles(4);
    compare_value(64'(ctrl), 64'd0, "ctrl after reset");
    compare_value(64'(cipo_oe), 64'd0, "cipo_oe while idle");
  endtask

  // First frame also shows the all zero reply after reset
  task automatic write_then_read();
    spi_word_t got;
    run_command({OP_WRITE, 8'h02, 16'h0, 32'hA5C3_1E77}, got);
    compare_value(got, 64'd0, "first reply after reset");
    run_command({OP_READ, 8'h02, 16'h0, 32'h0}, got);
    compare_value(got, {OP_WRITE, 8'h02, 16'd1, 32'hA5C3_1E77}, "write reply");
    run_command({OP_READ, 8'h03, 16'h0, 32'h0}, got);
    compare_value(got, {OP_READ, 8'h02, 16'd2, 32'hA5C3_1E77}, "read reply");
  endtask

  task automatic ctrl_from_reg0();
    spi_word_t got;
    run_command({OP_WRITE, 8'h00, 16'h0, 32'h1234_8001}, got);
    compare_value(64'(ctrl), 64'h1234_8001, "ctrl after register 0 write");
  endtask

  task automatic error_replies();
    spi_word_t got;
    // Unknown opcode followed by a write past the bank
    run_command({8'h55, 8'h01, 16'h0, 32'hDEAD_BEEF}, got);
    run_command({OP_WRITE, 8'h09, 16'h0, 32'h0BAD_0BAD}, got);
    compare_value(64'(got[63:56]), 64'(OP_ERROR), "unknown opcode reply");
    // Register 1 is the target of the bad opcode and of a wrapped address 9
    run_command({OP_READ, 8'h01, 16'h0, 32'h0}, got);
    compare_value(64'(got[63:56]), 64'(OP_ERROR), "out of range reply");
    compare_value(64'(got[31:0]), 64'd0, "error reply data");
  endtask

  task automatic aborted_frame();
    spi_word_t got;
    spi_xfer_word({OP_WRITE, 8'h01, 16'h0, 32'hFFFF_0000}, 13, got);
    // First byte of the pending reply was already on the line
    compare_value(64'(got[7:0]), 64'(exp_reply[7:0]), "aborted frame first byte");
    run_command({OP_READ, 8'h01, 16'h0, 32'h0}, got);
    run_command({OP_READ, 8'h02, 16'h0, 32'h0}, got);
  endtask

  task automatic random_traffic();
    spi_word_t   got;
    logic [31:0] r;
    logic [31:0] d;
    spi_opcode_t op;
    spi_addr_t   addr;
    for (int n = 0; n < 30; n++) begin
      r = next_random();
      d = next_random();
      op = r[0] ? OP_WRITE : OP_READ;
      addr = {6'd0, r[2:1]};
      run_command({op, addr, 16'h0, d}, got);
    end
    // Flush so the last random reply is compared too
    run_command({OP_READ, 8'h00, 16'h0, 32'h0}, got);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Simulation timed out before the tests finished");
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    sck       = 1'b0;
    cs_n      = 1'b1;
    copi      = 1'b0;
    ref_cnt   = '0;
    exp_reply = '0;
    rng_state = 32'd56308;
    for (int i = 0; i < 256; i++) begin
      ref_regs[i] = '0;
    end
    wait_cycles(2);
    arst_n = 1'b1;
    idle_after_reset();
    write_then_read();
    ctrl_from_reg0();
    error_replies();
    aborted_frame();
    random_traffic();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: project.f
src/spi_pkg.sv
src/spi_input_sync.sv
src/spi_byte_engine.sv
src/spi_word_framer.sv
src/spi_command_regs.sv
src/spi_word_target.sv
tests/tb_spi_word_target.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, exit status gives the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f project.f --top-module tb_spi_word_target -o sim_tb \
  && ./obj_dir/sim_tb \
  || { echo "simulation failed"; exit 1; }
